// ==== src/perf_cfg_pkg.sv ====
package perf_cfg_pkg;

	localparam int STAT_W = 32;
	localparam int ADDR_W = 10;
	localparam int NUM_STATS = 15;

	// Order sets the register layout above STAT_BASE_OFS
	typedef enum logic [3:0] {
		STAT_ST_ACTIVE, STAT_ST_IDLE, STAT_ST_BUSY,
		STAT_LDREQ_ACTIVE, STAT_LDREQ_IDLE, STAT_LDREQ_BUSY,
		STAT_LDDAT_ACTIVE, STAT_LDDAT_IDLE, STAT_LDDAT_BUSY,
		STAT_ST_PASS, STAT_ST_FAIL,
		STAT_LD_PASS, STAT_LD_FAIL,
		STAT_ST_SENT, STAT_LD_SENT
	} stat_id_t;

	// Register map
	localparam logic [ADDR_W-1:0] CTRL_OFS = 10'h300;
	localparam logic [ADDR_W-1:0] STAT_BASE_OFS = 10'h304;
	localparam logic [ADDR_W-1:0] ERR_OFS = 10'h340;

	localparam logic [STAT_W-1:0] DEAD_WORD = 32'h0000_DEAD;

endpackage

// ==== src/link_pkg.sv ====
package link_pkg;

	typedef enum logic [1:0] {
		LINK_NONE,
		LINK_IDLE,
		LINK_ACTIVE,
		LINK_BUSY
	} link_class_t;

	localparam int COOKIE_W = 12;
	localparam int COOKIE_ST_BIT = 11;
	localparam int ERR_STATUS_W = 3;
	localparam int STATUS_W = 2;

	typedef struct packed {
		logic [STATUS_W-1:0] status;
		logic error;
		logic [ERR_STATUS_W-1:0] err_status;
	} rsp_err_t;

endpackage

// ==== src/perf_event_if.sv ====
`timescale 1ns/1ps

interface perf_event_if;
	import link_pkg::*;

	// Per-cycle class of each link, NONE counts nothing
	link_class_t st_class;
	link_class_t ldreq_class;
	link_class_t lddat_class;

	// Single-cycle strobes
	logic st_sent;
	logic ld_sent;
	logic st_pass;
	logic st_fail;
	logic ld_pass;
	logic ld_fail;

	modport mon (output st_class, ldreq_class, lddat_class,
		st_sent, ld_sent, st_pass, st_fail, ld_pass, ld_fail);
	modport bank (input st_class, ldreq_class, lddat_class,
		st_sent, ld_sent, st_pass, st_fail, ld_pass, ld_fail);
endinterface

// ==== src/link_activity_monitor.sv ====
`timescale 1ns/1ps

module link_activity_monitor (
	input logic axi_aclk,
	input logic axi_aresetn,
	input logic tvalid_i,
	input logic tready_i,
	input logic eop_i,
	output link_pkg::link_class_t class_o,
	output logic sent_o
);
	import link_pkg::*;

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			class_o <= LINK_NONE;
			sent_o <= 1'b0;
		end
		else
		begin
			// Busy whenever ready is low, valid does not matter
			if (!tready_i)
				class_o <= LINK_BUSY;
			else if (!tvalid_i)
				class_o <= LINK_IDLE;
			else
				class_o <= LINK_ACTIVE;
			sent_o <= tvalid_i & tready_i & eop_i;
		end
	end
endmodule

// ==== src/response_classifier.sv ====
`timescale 1ns/1ps

module response_classifier (
	input logic axi_aclk,
	input logic axi_aresetn,
	input logic tvalid_i,
	input logic tready_i,
	input logic eop_i,
	input logic [link_pkg::COOKIE_W-1:0] cookie_i,
	input logic error_i,
	input logic [link_pkg::ERR_STATUS_W-1:0] err_status_i,
	input logic [link_pkg::STATUS_W-1:0] status_i,
	input logic clear_i,
	perf_event_if.mon ev,
	output link_pkg::rsp_err_t last_st_err_o
);
	import link_pkg::*;

	logic rsp_end;
	logic st_rsp;
	logic st_bad;
	logic ld_bad;

	assign rsp_end = tvalid_i & tready_i & eop_i;
	// Cookie bit set means the response belongs to an MSGST request
	assign st_rsp = cookie_i[COOKIE_ST_BIT];
	assign st_bad = |err_status_i;
	assign ld_bad = error_i | (|err_status_i) | (|status_i);

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			ev.st_pass <= 1'b0;
			ev.st_fail <= 1'b0;
			ev.ld_pass <= 1'b0;
			ev.ld_fail <= 1'b0;
		end
		else
		begin
			ev.st_pass <= rsp_end & st_rsp & ~st_bad;
			ev.st_fail <= rsp_end & st_rsp & st_bad;
			ev.ld_pass <= rsp_end & ~st_rsp & ~ld_bad;
			ev.ld_fail <= rsp_end & ~st_rsp & ld_bad;
		end
	end

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn || clear_i)
			last_st_err_o <= '0;
		else if (rsp_end && st_rsp)
			last_st_err_o <= '{status: status_i, error: error_i, err_status: err_status_i};
	end
endmodule

// ==== src/stat_counter_bank.sv ====
`timescale 1ns/1ps

module stat_counter_bank (
	input logic axi_aclk,
	input logic axi_aresetn,
	perf_event_if.bank ev,
	input logic clear_i,
	input perf_cfg_pkg::stat_id_t rd_id_i,
	output logic [perf_cfg_pkg::STAT_W-1:0] rd_value_o
);
	import perf_cfg_pkg::*;
	import link_pkg::*;

	logic [STAT_W-1:0] cnt [NUM_STATS];
	logic [NUM_STATS-1:0] inc;

	// Bit order matches the active, idle, busy order of stat_id_t
	function automatic logic [2:0] class_hit(input link_class_t c);
		class_hit = {c == LINK_BUSY, c == LINK_IDLE, c == LINK_ACTIVE};
	endfunction

	//********************
	// Increment enables
	//********************
	always_comb
	begin
		inc = '0;
		inc[STAT_ST_BUSY:STAT_ST_ACTIVE] = class_hit(ev.st_class);
		inc[STAT_LDREQ_BUSY:STAT_LDREQ_ACTIVE] = class_hit(ev.ldreq_class);
		inc[STAT_LDDAT_BUSY:STAT_LDDAT_ACTIVE] = class_hit(ev.lddat_class);
		inc[STAT_ST_PASS] = ev.st_pass;
		inc[STAT_ST_FAIL] = ev.st_fail;
		inc[STAT_LD_PASS] = ev.ld_pass;
		inc[STAT_LD_FAIL] = ev.ld_fail;
		inc[STAT_ST_SENT] = ev.st_sent;
		inc[STAT_LD_SENT] = ev.ld_sent;
	end

	//********************
	// Counters
	//********************
	always_ff @(posedge axi_aclk)
	begin
		for (int i = 0; i < NUM_STATS; i++)
		begin
			if (!axi_aresetn || clear_i)
				cnt[i] <= '0;
			else if (inc[i])
				cnt[i] <= cnt[i] + 1'b1;
		end
	end

	// Index 15 has no counter behind it
	assign rd_value_o = (int'(rd_id_i) < NUM_STATS) ? cnt[rd_id_i] : '0;
endmodule

// ==== src/axi_lite_stat_regs.sv ====
`timescale 1ns/1ps

module axi_lite_stat_regs (
	input logic axi_aclk,
	input logic axi_aresetn,
	input logic [perf_cfg_pkg::ADDR_W-1:0] awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input logic [perf_cfg_pkg::STAT_W-1:0] wdata_i,
	input logic [perf_cfg_pkg::STAT_W/8-1:0] wstrb_i,
	input logic wvalid_i,
	output logic wready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input logic bready_i,
	input logic [perf_cfg_pkg::ADDR_W-1:0] araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output logic [perf_cfg_pkg::STAT_W-1:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o,
	input logic rready_i,
	output perf_cfg_pkg::stat_id_t rd_id_o,
	input logic [perf_cfg_pkg::STAT_W-1:0] rd_value_i,
	input link_pkg::rsp_err_t last_st_err_i,
	output logic clear_o
);
	import perf_cfg_pkg::*;
	import link_pkg::*;

	logic rel;
	logic rel_r;
	logic wr_open;
	logic [ADDR_W-1:0] wr_addr;
	logic [STAT_W-1:0] ctrl;
	logic [ADDR_W-1:0] stat_ofs;
	logic stat_hit;
	logic ar_hs;
	logic w_hs;

	// Open read is simply rvalid, since rdata is ready one cycle after AR
	assign awready_o = ~wr_open & ~rvalid_o & ~arvalid_i & rel_r;
	assign arready_o = ~rvalid_o & ~wr_open & rel_r;
	assign wready_o = wr_open & ~bvalid_o;
	assign bresp_o = 2'b00;
	assign rresp_o = 2'b00;
	assign ar_hs = arvalid_i & arready_o;
	assign w_hs = wvalid_i & wready_o;
	assign clear_o = ctrl[0];

	assign stat_ofs = araddr_i - STAT_BASE_OFS;
	assign stat_hit = (araddr_i >= STAT_BASE_OFS) && (araddr_i < ERR_OFS)
		&& (araddr_i[1:0] == 2'b00);
	assign rd_id_o = stat_id_t'(stat_ofs[5:2]);

	//********************
	// Write channel
	//********************
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			rel <= 1'b0;
			rel_r <= 1'b0;
			wr_open <= 1'b0;
			wr_addr <= '0;
			bvalid_o <= 1'b0;
			ctrl <= '0;
		end
		else
		begin
			rel <= 1'b1;
			rel_r <= rel;
			if (awvalid_i && awready_o)
			begin
				wr_open <= 1'b1;
				wr_addr <= awaddr_i;
			end
			else if (bvalid_o && bready_i)
				wr_open <= 1'b0;
			if (w_hs)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
			if (w_hs && wr_addr == CTRL_OFS)
			begin
				for (int b = 0; b < STAT_W/8; b++)
					if (wstrb_i[b])
						ctrl[b*8 +: 8] <= wdata_i[b*8 +: 8];
			end
		end
	end

	//********************
	// Read channel
	//********************
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			rvalid_o <= 1'b0;
		else if (ar_hs)
			rvalid_o <= 1'b1;
		else if (rready_i)
			rvalid_o <= 1'b0;
	end

	always_ff @(posedge axi_aclk)
	begin
		if (ar_hs)
		begin
			if (araddr_i == CTRL_OFS)
				rdata_o <= ctrl;
			else if (stat_hit)
				rdata_o <= rd_value_i;
			else if (araddr_i == ERR_OFS)
				rdata_o <= {{(STAT_W - $bits(rsp_err_t)){1'b0}}, last_st_err_i};
			else
				rdata_o <= DEAD_WORD;
		end
	end
endmodule

// ==== src/msgstld_perf_top.sv ====
`timescale 1ns/1ps

module msgstld_perf_top (
	input logic axi_aclk,
	input logic axi_aresetn,
	// MSGST request link
	input logic st_tvalid_i,
	input logic st_tready_i,
	input logic st_eop_i,
	// MSGLD request link
	input logic ldreq_tvalid_i,
	input logic ldreq_tready_i,
	// MSGLD data link and response fields
	input logic lddat_tvalid_i,
	input logic lddat_tready_i,
	input logic lddat_eop_i,
	input logic [link_pkg::COOKIE_W-1:0] lddat_cookie_i,
	input logic lddat_error_i,
	input logic [link_pkg::ERR_STATUS_W-1:0] lddat_err_status_i,
	input logic [link_pkg::STATUS_W-1:0] lddat_status_i,
	// AXI-lite
	input logic [perf_cfg_pkg::ADDR_W-1:0] awaddr_i,
	input logic awvalid_i,
	output logic awready_o,
	input logic [perf_cfg_pkg::STAT_W-1:0] wdata_i,
	input logic [perf_cfg_pkg::STAT_W/8-1:0] wstrb_i,
	input logic wvalid_i,
	output logic wready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input logic bready_i,
	input logic [perf_cfg_pkg::ADDR_W-1:0] araddr_i,
	input logic arvalid_i,
	output logic arready_o,
	output logic [perf_cfg_pkg::STAT_W-1:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o,
	input logic rready_i
);
	perf_event_if ev ();

	logic clear;
	perf_cfg_pkg::stat_id_t rd_id;
	logic [perf_cfg_pkg::STAT_W-1:0] rd_value;
	link_pkg::rsp_err_t last_st_err;

	link_activity_monitor st_mon (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.tvalid_i(st_tvalid_i), .tready_i(st_tready_i), .eop_i(st_eop_i),
		.class_o(ev.st_class), .sent_o(ev.st_sent)
	);

	// Every MSGLD request handshake is a whole request
	link_activity_monitor ldreq_mon (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.tvalid_i(ldreq_tvalid_i), .tready_i(ldreq_tready_i), .eop_i(1'b1),
		.class_o(ev.ldreq_class), .sent_o(ev.ld_sent)
	);

	link_activity_monitor lddat_mon (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.tvalid_i(lddat_tvalid_i), .tready_i(lddat_tready_i), .eop_i(lddat_eop_i),
		.class_o(ev.lddat_class), .sent_o()
	);

	response_classifier rsp_cls (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.tvalid_i(lddat_tvalid_i), .tready_i(lddat_tready_i), .eop_i(lddat_eop_i),
		.cookie_i(lddat_cookie_i), .error_i(lddat_error_i),
		.err_status_i(lddat_err_status_i), .status_i(lddat_status_i),
		.clear_i(clear), .ev(ev.mon), .last_st_err_o(last_st_err)
	);

	stat_counter_bank bank (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn), .ev(ev.bank),
		.clear_i(clear), .rd_id_i(rd_id), .rd_value_o(rd_value)
	);

	axi_lite_stat_regs regs (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wstrb_i(wstrb_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
		.rd_id_o(rd_id), .rd_value_i(rd_value), .last_st_err_i(last_st_err),
		.clear_o(clear)
	);
endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic axi_aclk,
	output logic axi_aresetn
);
	// 4 ns period
	initial
	begin
		axi_aclk = 1'b0;
		forever #2 axi_aclk = ~axi_aclk;
	end

	initial
	begin
		axi_aresetn = 1'b0;
		repeat (2) @(posedge axi_aclk);
		axi_aresetn <= 1'b1;
	end
endmodule

// ==== test/msgstld_perf_assertions.sv ====
`timescale 1ns/1ps

module msgstld_perf_assertions (
	input logic axi_aclk,
	input logic axi_aresetn,
	input logic rvalid_o,
	input logic rready_i,
	input logic [31:0] rdata_o,
	input logic bvalid_o,
	input logic wvalid_i,
	input logic wready_o,
	input logic arready_o
);
	// Read data held until taken
	rvalid_stable: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
		else $error("rvalid dropped or rdata changed before rready");

	// Write response only after write data
	bvalid_after_w: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		$rose(bvalid_o) |-> $past(wvalid_i && wready_o))
		else $error("bvalid rose without a W handshake");

	arready_low_in_read: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
		rvalid_o |-> !arready_o)
		else $error("arready high while a read is open");
endmodule

bind axi_lite_stat_regs msgstld_perf_assertions axi_checks (
	.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
	.rvalid_o(rvalid_o), .rready_i(rready_i), .rdata_o(rdata_o),
	.bvalid_o(bvalid_o), .wvalid_i(wvalid_i), .wready_o(wready_o),
	.arready_o(arready_o)
);

// ==== test/msgstld_perf_tb.sv ====
`timescale 1ns/1ps

module msgstld_perf_tb;
	import perf_cfg_pkg::*;
	import link_pkg::*;

	localparam int NUM_ROWS = 9;
	localparam int MAX_ROW_CYCLES = 40;
	localparam int DUMP_CYCLES = 20 * 6;
	localparam int HS_TIMEOUT = 20;
	localparam int WATCHDOG_NS = NUM_ROWS * (MAX_ROW_CYCLES + DUMP_CYCLES) * 4 * 4;

	typedef struct {
		int cycles;
		int ctrl_wr;
		logic [COOKIE_W-1:0] cookie;
		logic error;
		logic [ERR_STATUS_W-1:0] err_status;
		logic [STATUS_W-1:0] status;
		logic dump;
	} row_t;

	logic axi_aclk;
	logic axi_aresetn;
	logic st_tvalid, st_tready, st_eop;
	logic ldreq_tvalid, ldreq_tready;
	logic lddat_tvalid, lddat_tready, lddat_eop;
	logic [COOKIE_W-1:0] cookie;
	logic error;
	logic [ERR_STATUS_W-1:0] err_status;
	logic [STATUS_W-1:0] status;
	logic [ADDR_W-1:0] awaddr, araddr;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [STAT_W-1:0] wdata;
	logic [3:0] wstrb;
	logic awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
	logic [1:0] bresp_o, rresp_o;
	logic [STAT_W-1:0] rdata_o;

	row_t rows [NUM_ROWS];
	logic [15:0] lfsr = 16'd26;
	int errors = 0;
	int timeouts = 0;

	// Reference model state
	logic [STAT_W-1:0] m_cnt [NUM_STATS];
	link_class_t m_cls [3];
	logic [5:0] m_strb;
	logic [STAT_W-1:0] m_ctrl;
	rsp_err_t m_err;
	logic [ADDR_W-1:0] m_wr_addr;
	logic [STAT_W-1:0] m_sampled;
	logic [STAT_W-1:0] exp_rdata;
	logic [STAT_W-1:0] exp_sampled;

	tb_clock_gen clk_gen (.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn));

	msgstld_perf_top dut0 (
		.axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
		.st_tvalid_i(st_tvalid), .st_tready_i(st_tready), .st_eop_i(st_eop),
		.ldreq_tvalid_i(ldreq_tvalid), .ldreq_tready_i(ldreq_tready),
		.lddat_tvalid_i(lddat_tvalid), .lddat_tready_i(lddat_tready), .lddat_eop_i(lddat_eop),
		.lddat_cookie_i(cookie), .lddat_error_i(error),
		.lddat_err_status_i(err_status), .lddat_status_i(status),
		.awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready_o),
		.wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready_o),
		.bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready),
		.araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready_o),
		.rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o), .rready_i(rready)
	);

	// Fibonacci LFSR, taps 16 14 13 11
	function logic next_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic link_class_t classify(input logic v, input logic r);
		if (!r)
			return LINK_BUSY;
		else if (!v)
			return LINK_IDLE;
		return LINK_ACTIVE;
	endfunction

	// Active, idle, busy order within each link
	function automatic int class_ofs(input link_class_t c);
		return (c == LINK_ACTIVE) ? 0 : (c == LINK_IDLE) ? 1 : 2;
	endfunction

	function automatic logic [STAT_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
		if (addr == CTRL_OFS)
			return m_ctrl;
		else if (addr >= STAT_BASE_OFS && addr < ERR_OFS && addr[1:0] == 2'b00)
			return m_cnt[int'((addr - STAT_BASE_OFS) >> 2)];
		else if (addr == ERR_OFS)
			return {{(STAT_W - $bits(rsp_err_t)){1'b0}}, m_err};
		return DEAD_WORD;
	endfunction

	//********************
	// Reference model
	//********************
	always @(posedge axi_aclk)
	begin
		logic rsp_end;
		logic st_rsp;
		logic bad;
		if (!axi_aresetn)
		begin
			for (int i = 0; i < NUM_STATS; i++)
				m_cnt[i] = '0;
			for (int l = 0; l < 3; l++)
				m_cls[l] = LINK_NONE;
			m_strb = '0;
			m_ctrl = '0;
			m_err = '0;
			m_sampled = '0;
		end
		else
		begin
			if (arvalid && arready_o)
			begin
				exp_rdata = expected_read(araddr);
				exp_sampled = m_sampled;
			end
			if (m_ctrl[0])
			begin
				for (int i = 0; i < NUM_STATS; i++)
					m_cnt[i] = '0;
				m_sampled = '0;
			end
			else
			begin
				// All three links are sampled in the same cycles
				if (m_cls[0] != LINK_NONE)
					m_sampled += 32'd1;
				for (int l = 0; l < 3; l++)
					if (m_cls[l] != LINK_NONE)
						m_cnt[3*l + class_ofs(m_cls[l])] += 32'd1;
				for (int k = 0; k < 6; k++)
					if (m_strb[k])
						m_cnt[int'(STAT_ST_PASS) + k] += 32'd1;
			end
			m_cls[0] = classify(st_tvalid, st_tready);
			m_cls[1] = classify(ldreq_tvalid, ldreq_tready);
			m_cls[2] = classify(lddat_tvalid, lddat_tready);
			rsp_end = lddat_tvalid & lddat_tready & lddat_eop;
			st_rsp = cookie[11];
			bad = error | (err_status != 0) | (status != 0);
			m_strb[0] = rsp_end & st_rsp & (err_status == 0);
			m_strb[1] = rsp_end & st_rsp & (err_status != 0);
			m_strb[2] = rsp_end & ~st_rsp & ~bad;
			m_strb[3] = rsp_end & ~st_rsp & bad;
			m_strb[4] = st_tvalid & st_tready & st_eop;
			m_strb[5] = ldreq_tvalid & ldreq_tready;
			if (m_ctrl[0])
				m_err = '0;
			else if (rsp_end && st_rsp)
				m_err = rsp_err_t'({status, error, err_status});
			if (awvalid && awready_o)
				m_wr_addr = awaddr;
			if (wvalid && wready_o && m_wr_addr == CTRL_OFS)
				m_ctrl = wdata;
		end
	end

	task automatic drive_links(input row_t r);
		@(posedge axi_aclk);
		st_tvalid <= next_bit();
		st_tready <= next_bit();
		st_eop <= next_bit();
		ldreq_tvalid <= next_bit();
		ldreq_tready <= next_bit();
		lddat_tvalid <= next_bit();
		lddat_tready <= next_bit();
		lddat_eop <= next_bit();
		cookie <= r.cookie;
		error <= r.error;
		err_status <= r.err_status;
		status <= r.status;
	endtask

	task automatic write_ctrl(input logic [STAT_W-1:0] value);
		int n;
		@(posedge axi_aclk);
		awaddr <= CTRL_OFS;
		awvalid <= 1'b1;
		n = 0;
		@(posedge axi_aclk);
		while (!awready_o && n < HS_TIMEOUT)
		begin
			@(posedge axi_aclk);
			n++;
		end
		awvalid <= 1'b0;
		wdata <= value;
		wstrb <= 4'hF;
		wvalid <= 1'b1;
		n = 0;
		@(posedge axi_aclk);
		while (!wready_o && n < HS_TIMEOUT)
		begin
			@(posedge axi_aclk);
			n++;
		end
		wvalid <= 1'b0;
		n = 0;
		@(posedge axi_aclk);
		while (!bvalid_o && n < HS_TIMEOUT)
		begin
			@(posedge axi_aclk);
			n++;
		end
		if (!bvalid_o)
		begin
			timeouts++;
			$display("Write to the control register did not complete in time");
		end
		assert (bresp_o == 2'b00)
		else
		begin
			errors++;
			$display("[ERROR] bresp_o: got 0x%h, expected 0x%h", bresp_o, 2'b00);
		end
	endtask

	task automatic check_reg(input logic [ADDR_W-1:0] addr, output logic [STAT_W-1:0] got,
		output logic [STAT_W-1:0] expv);
		int n;
		@(posedge axi_aclk);
		araddr <= addr;
		arvalid <= 1'b1;
		// First rvalid cycle stalls on rready
		rready <= 1'b0;
		n = 0;
		@(posedge axi_aclk);
		while (!arready_o && n < HS_TIMEOUT)
		begin
			@(posedge axi_aclk);
			n++;
		end
		arvalid <= 1'b0;
		n = 0;
		@(posedge axi_aclk);
		while (!rvalid_o && n < HS_TIMEOUT)
		begin
			@(posedge axi_aclk);
			n++;
		end
		if (!rvalid_o)
		begin
			timeouts++;
			$display("Read of offset 0x%h got no response in time", addr);
		end
		rready <= 1'b1;
		@(posedge axi_aclk);
		got = rdata_o;
		expv = exp_rdata;
		assert (got == expv)
		else
		begin
			errors++;
			$display("[ERROR] rdata_o at 0x%h: got 0x%h, expected 0x%h", addr, got, expv);
		end
		assert (rresp_o == 2'b00)
		else
		begin
			errors++;
			$display("[ERROR] rresp_o at 0x%h: got 0x%h, expected 0x%h", addr, rresp_o, 2'b00);
		end
	endtask

	task automatic dump_regs();
		logic [STAT_W-1:0] got [NUM_STATS];
		logic [STAT_W-1:0] smp [NUM_STATS];
		logic [STAT_W-1:0] g;
		logic [STAT_W-1:0] e;
		logic [STAT_W-1:0] sum;
		// Quiet links so active and busy stop moving
		repeat (3)
		begin
			@(posedge axi_aclk);
			{st_tvalid, ldreq_tvalid, lddat_tvalid} <= 3'b000;
			{st_tready, ldreq_tready, lddat_tready} <= 3'b111;
		end
		check_reg(CTRL_OFS, g, e);
		for (int i = 0; i < NUM_STATS; i++)
		begin
			check_reg(STAT_BASE_OFS + ADDR_W'(4 * i), got[i], e);
			smp[i] = exp_sampled;
		end
		check_reg(ERR_OFS, g, e);
		check_reg(10'h100, g, e);
		// Only idle still moves, so the sum is the cycle count at the idle read
		for (int l = 0; l < 3; l++)
		begin
			sum = got[3*l] + got[3*l+1] + got[3*l+2];
			assert (sum == smp[3*l+1])
			else
			begin
				errors++;
				$display("[ERROR] link %0d active+idle+busy: got 0x%h, expected 0x%h", l,
					sum, smp[3*l+1]);
			end
		end
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		{st_tvalid, st_tready, st_eop} = 3'b010;
		{ldreq_tvalid, ldreq_tready} = 2'b01;
		{lddat_tvalid, lddat_tready, lddat_eop} = 3'b010;
		cookie = '0;
		error = 1'b0;
		err_status = '0;
		status = '0;
		awaddr = '0;
		araddr = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b1;
		rready = 1'b1;

		//          cycles ctrl cookie  err es    st    dump
		rows[0] = '{0, -1, 12'h000, 1'b0, 3'd0, 2'd0, 1'b1};
		rows[1] = '{40, -1, 12'h800, 1'b1, 3'd0, 2'd2, 1'b1};
		rows[2] = '{40, -1, 12'h800, 1'b1, 3'd3, 2'd1, 1'b1};
		rows[3] = '{40, -1, 12'h123, 1'b1, 3'd0, 2'd0, 1'b1};
		rows[4] = '{40, -1, 12'h0AB, 1'b0, 3'd0, 2'd2, 1'b0};
		rows[5] = '{40, -1, 12'h456, 1'b0, 3'd4, 2'd0, 1'b0};
		rows[6] = '{40, -1, 12'h000, 1'b0, 3'd0, 2'd0, 1'b1};
		rows[7] = '{30, 1, 12'h800, 1'b0, 3'd6, 2'd0, 1'b1};
		rows[8] = '{40, 0, 12'h9FF, 1'b1, 3'd5, 2'd1, 1'b1};

		wait (axi_aresetn);
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			if (rows[r].ctrl_wr >= 0)
				write_ctrl(STAT_W'(rows[r].ctrl_wr));
			for (int c = 0; c < rows[r].cycles; c++)
				drive_links(rows[r]);
			if (rows[r].dump)
				dump_regs();
		end

		$display("Value errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end
endmodule

// ==== filelist.f ====
src/perf_cfg_pkg.sv
src/link_pkg.sv
src/perf_event_if.sv
src/link_activity_monitor.sv
src/response_classifier.sv
src/stat_counter_bank.sv
src/axi_lite_stat_regs.sv
src/msgstld_perf_top.sv
test/tb_clock_gen.sv
test/msgstld_perf_assertions.sv
test/msgstld_perf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module msgstld_perf_tb -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
	exit 1
fi
exit 0
